// ==== Bender.yml ====
package:
  name: exe_stage

sources:
  - logic/exe_pkg.sv
  - logic/alu.sv
  - logic/div_ctrl.sv
  - logic/div_iter_counter.sv
  - logic/div_datapath.sv
  - logic/exe_stage.sv
  - logic/exe_top.sv
  - target: simulation
    files:
      - bench/exe_tb.sv

// ==== bench/exe_tb.sv ====
`timescale 1ns/1ps

module exe_tb;

    import exe_pkg::*;

    // Everything one instruction should produce at handoff
    typedef struct packed {
        es_to_ms_t      ms;
        data_sram_req_t sram;
        es_fwd_t        fwd;
    } expect_t;

    localparam int timeout_cycles = 200;

    logic           clk;
    logic           reset;
    logic           ds_to_es_valid;
    ds_to_es_t      ds_to_es;
    logic           es_allowin;
    logic           es_to_ms_valid;
    es_to_ms_t      es_to_ms;
    logic           ms_allowin;
    data_sram_req_t data_sram;
    es_fwd_t        es_fwd;

    int          seed = 51297;
    int          checks = 0;
    int          errors = 0;
    int          test_checks;
    int          test_errors;
    string       cur_test = "reset";
    logic        stall_on = 1'b0;
    logic        bubbles_on = 1'b0;
    logic [31:0] next_pc = 32'h1c00_0000;
    expect_t     exp_q[$];
    expect_t     exp_head;
    logic        held;
    es_to_ms_t   held_pkt;

    exe_top #(
        .XLEN (xlen)
    ) dut0 (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_allowin     (es_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms       (es_to_ms),
        .ms_allowin     (ms_allowin),
        .data_sram      (data_sram),
        .es_fwd         (es_fwd)
    );

    always #10 clk = ~clk;

    // Memory stage back-pressure
    always @(negedge clk) begin
        ms_allowin = !stall_on || ($unsigned($random(seed)) % 3 != 0);
    end

    function automatic expect_t exe_model(input ds_to_es_t d);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] am;
        logic [31:0] bm;
        logic [31:0] q;
        logic [31:0] rm;
        logic        sa;
        logic        sb;
        logic        sgn;
        expect_t     e;
        a = d.src1_is_pc ? d.pc : d.rj_value;
        b = d.src2_is_imm ? d.imm : d.rkd_value;
        sgn = (d.alu_op == op_div) || (d.alu_op == op_mod);
        sa = sgn && a[31];
        sb = sgn && b[31];
        am = sa ? -a : a;
        bm = sb ? -b : b;
        if (b == 32'd0) begin
            q = 32'hffff_ffff;
            rm = a;
        end else begin
            q = am / bm;
            rm = am % bm;
            q = (sa ^ sb) ? -q : q;
            rm = sa ? -rm : rm;
        end
        case (d.alu_op)
            op_add:  r = a + b;
            op_sub:  r = a + ~b + 32'd1;
            op_slt:  r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            op_sltu: r = {31'd0, a < b};
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_nor:  r = ~(a | b);
            op_xor:  r = a ^ b;
            op_sll:  r = a << b[4:0];
            op_srl:  r = a >> b[4:0];
            op_sra:  r = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            op_lui:  r = b;
            op_div, op_divu: r = q;
            default: r = rm;
        endcase
        e.ms.res_from_mem = d.res_from_mem;
        e.ms.gr_we        = d.gr_we;
        e.ms.dest         = d.dest;
        e.ms.alu_result   = r;
        e.ms.pc           = d.pc;
        e.sram.en         = d.res_from_mem || d.mem_we;
        e.sram.wen        = d.mem_we ? 4'hf : 4'h0;
        e.sram.addr       = r;
        e.sram.wdata      = d.rkd_value;
        e.fwd.wr_valid    = d.gr_we;
        e.fwd.load_valid  = d.res_from_mem;
        e.fwd.dest        = d.dest;
        e.fwd.result      = r;
        return e;
    endfunction

    task automatic check_es_to_ms(input string what, input es_to_ms_t exp, input es_to_ms_t act);
        checks++;
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_sram(input data_sram_req_t exp, input data_sram_req_t act);
        checks++;
        if (exp !== act) begin
            $display("Mismatch %s data_sram: expected %h actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_fwd(input es_fwd_t exp, input es_fwd_t act);
        checks++;
        if (exp !== act) begin
            $display("Mismatch %s es_fwd: expected %h actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %b actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // Handoffs pop the scoreboard queue and transfers push it
    always @(posedge clk) begin
        if (reset) begin
            held = 1'b0;
        end else begin
            if (held && !es_to_ms_valid) begin
                $display("Error in %s: es_to_ms_valid dropped while memory stalled", cur_test);
                errors++;
            end else if (held) begin
                check_es_to_ms("stall hold", held_pkt, es_to_ms);
            end
            if (es_to_ms_valid && !ms_allowin) begin
                check_flag("es_allowin", 1'b0, es_allowin);
            end
            if (es_to_ms_valid && ms_allowin) begin
                if (exp_q.size() == 0) begin
                    $display("Error in %s: handoff with no instruction outstanding", cur_test);
                    errors++;
                end else begin
                    exp_head = exp_q.pop_front();
                    check_es_to_ms("es_to_ms", exp_head.ms, es_to_ms);
                    check_sram(exp_head.sram, data_sram);
                    check_fwd(exp_head.fwd, es_fwd);
                end
            end
            held = es_to_ms_valid && !ms_allowin;
            held_pkt = es_to_ms;
            if (ds_to_es_valid && es_allowin) begin
                exp_q.push_back(exe_model(ds_to_es));
            end
        end
    end

    function automatic ds_to_es_t rand_pkt(input alu_op_e op);
        ds_to_es_t p;
        p = '0;
        p.alu_op    = op;
        p.gr_we     = 1'b1;
        p.dest      = 5'($random(seed));
        p.imm       = $random(seed);
        p.rj_value  = $random(seed);
        p.rkd_value = $random(seed);
        return p;
    endfunction

    task automatic send(input ds_to_es_t pkt);
        int   waited;
        int   gap;
        logic taken;
        pkt.pc = next_pc;
        next_pc = next_pc + 32'd4;
        ds_to_es = pkt;
        ds_to_es_valid = 1'b1;
        waited = 0;
        taken = 1'b0;
        while (!taken && waited < timeout_cycles) begin
            @(posedge clk);
            taken = es_allowin;
            @(negedge clk);
            waited++;
        end
        ds_to_es_valid = 1'b0;
        if (!taken) begin
            $display("Timeout in %s: stage did not accept an instruction", cur_test);
            errors++;
        end
        if (bubbles_on) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in %s: %0d instructions never reached memory", cur_test,
                     exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        wait_drain();
        $display("test %s: %0d checks, %0d errors", cur_test, checks - test_checks,
                 errors - test_errors);
    endtask

    task automatic run_alu();
        ds_to_es_t   p;
        logic [31:0] amts[3];
        alu_op_e     ops[3];
        amts = '{32'd31, 32'd32, 32'd63};
        ops = '{op_sll, op_srl, op_sra};
        for (int i = 0; i < 80; i++) begin
            send(rand_pkt(alu_op_e'($unsigned($random(seed)) % 12)));
        end
        for (int k = 0; k < 9; k++) begin
            p = rand_pkt(ops[k % 3]);
            p.rkd_value = amts[k / 3];
            send(p);
        end
        // Operands where signed and unsigned order disagree
        for (int k = 0; k < 4; k++) begin
            p = rand_pkt(k[0] ? op_sltu : op_slt);
            p.rj_value  = k[1] ? 32'd1 : 32'h8000_0000;
            p.rkd_value = k[1] ? 32'hffff_ffff : 32'd1;
            send(p);
        end
    endtask

    task automatic run_operand_select();
        ds_to_es_t p;
        alu_op_e   ops[3];
        ops = '{op_add, op_sub, op_lui};
        for (int i = 0; i < 24; i++) begin
            p = rand_pkt(ops[(i / 4) % 3]);
            p.src1_is_pc  = i[0];
            p.src2_is_imm = i[1];
            send(p);
        end
    endtask

    task automatic run_divide();
        ds_to_es_t p;
        alu_op_e   ops[4];
        ops = '{op_div, op_divu, op_mod, op_modu};
        for (int i = 0; i < 24; i++) begin
            p = rand_pkt(ops[i % 4]);
            if (i % 3 == 0) begin
                p.rkd_value = p.rkd_value >> 20;
            end
            send(p);
        end
        for (int i = 0; i < 8; i++) begin
            p = rand_pkt(ops[i % 4]);
            p.rkd_value = (i < 4) ? 32'd0 : 32'hffff_ffff;
            if (i >= 4) begin
                p.rj_value = 32'h8000_0000;
            end
            send(p);
        end
    endtask

    task automatic run_mem();
        ds_to_es_t p;
        for (int i = 0; i < 16; i++) begin
            p = rand_pkt(op_add);
            p.src2_is_imm  = 1'b1;
            p.res_from_mem = !i[0];
            p.mem_we       = i[0];
            p.gr_we        = !i[0];
            send(p);
        end
    endtask

    task automatic run_backpressure();
        ds_to_es_t p;
        int        kind;
        stall_on = 1'b1;
        bubbles_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            kind = $unsigned($random(seed)) % 8;
            if (kind == 0) begin
                p = rand_pkt(alu_op_e'(12 + $unsigned($random(seed)) % 4));
            end else if (kind == 1) begin
                p = rand_pkt(op_add);
                p.src2_is_imm  = 1'b1;
                p.mem_we       = i[0];
                p.res_from_mem = !i[0];
            end else begin
                p = rand_pkt(alu_op_e'($unsigned($random(seed)) % 12));
            end
            send(p);
        end
        wait_drain();
        stall_on = 1'b0;
        bubbles_on = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es = '0;
        ms_allowin = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test("reset_idle");
        repeat (3) begin
            @(negedge clk);
            check_flag("es_to_ms_valid", 1'b0, es_to_ms_valid);
            check_flag("data_sram.en", 1'b0, data_sram.en);
            check_flag("es_fwd.wr_valid", 1'b0, es_fwd.wr_valid);
            check_flag("es_fwd.load_valid", 1'b0, es_fwd.load_valid);
            check_flag("es_allowin", 1'b1, es_allowin);
        end
        end_test();

        begin_test("alu_random");
        run_alu();
        end_test();
        begin_test("operand_select");
        run_operand_select();
        end_test();
        begin_test("divide");
        run_divide();
        end_test();
        begin_test("mem_access");
        run_mem();
        end_test();
        begin_test("backpressure");
        run_backpressure();
        end_test();

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  exe_pkg::alu_op_e alu_op,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    output logic [31:0]      result
);

    import exe_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic [31:0] diff;
    logic        lt_signed;
    logic        lt_unsigned;

    // Only the low five bits count for shifts
    assign shamt = src2[4:0];

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            op_add: begin
                result = sum;
            end
            op_sub: begin
                result = diff;
            end
            op_slt: begin
                result = {31'd0, lt_signed};
            end
            op_sltu: begin
                result = {31'd0, lt_unsigned};
            end
            op_and: begin
                result = src1 & src2;
            end
            op_or: begin
                result = src1 | src2;
            end
            op_nor: begin
                result = ~(src1 | src2);
            end
            op_xor: begin
                result = src1 ^ src2;
            end
            op_sll: begin
                result = src1 << shamt;
            end
            op_srl: begin
                result = src1 >> shamt;
            end
            op_sra: begin
                result = $unsigned($signed(src1) >>> shamt);
            end
            op_lui: begin
                // Immediate already shifted up by decode
                result = src2;
            end
            default: begin
                // Divide ops come from the divider
                result = 32'd0;
            end
        endcase
    end

endmodule

// ==== logic/div_ctrl.sv ====
`timescale 1ns/1ps

module div_ctrl #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 last_step,
    input  logic                 ack,
    output exe_pkg::div_state_e  state,
    output logic                 step_en,
    output logic                 load
);

    import exe_pkg::*;

    div_state_e state_nxt;

    assign load    = (state == div_idle) && start;
    assign step_en = (state == div_busy);

    always_comb begin
        state_nxt = state;
        case (state)
            div_idle: begin
                if (start) begin
                    state_nxt = div_busy;
                end
            end
            div_busy: begin
                if (last_step) begin
                    state_nxt = div_done;
                end
            end
            div_done: begin
                // Result held until the stage hands the instruction off
                if (ack) begin
                    state_nxt = div_idle;
                end
            end
            default: begin
                state_nxt = div_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= div_idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== logic/div_datapath.sv ====
`timescale 1ns/1ps

module div_datapath #(
    parameter int XLEN = 32
) (
    input  logic               clk,
    input  logic               load,
    input  logic               step_en,
    input  exe_pkg::div_req_t  req,
    output logic [XLEN-1:0]    result
);

    logic [XLEN-1:0] divisor_mag;
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] quo;
    logic            quo_neg;
    logic            rem_neg;
    logic            want_rem;
    logic            by_zero;
    logic [XLEN-1:0] dividend_raw;
    logic            dividend_sign;
    logic            divisor_sign;
    logic [XLEN:0]   rem_shift;
    logic            fits;
    logic [XLEN-1:0] quo_out;
    logic [XLEN-1:0] rem_out;

    assign dividend_sign = req.is_signed && req.dividend[XLEN-1];
    assign divisor_sign  = req.is_signed && req.divisor[XLEN-1];

    // Bring in the next dividend bit, then try the subtract
    assign rem_shift = {rem, quo[XLEN-1]};
    assign fits      = rem_shift >= {1'b0, divisor_mag};

    always_ff @(posedge clk) begin
        if (load) begin
            quo          <= dividend_sign ? -req.dividend : req.dividend;
            divisor_mag  <= divisor_sign ? -req.divisor : req.divisor;
            rem          <= '0;
            quo_neg      <= dividend_sign ^ divisor_sign;
            rem_neg      <= dividend_sign;
            want_rem     <= req.want_rem;
            by_zero      <= (req.divisor == '0);
            dividend_raw <= req.dividend;
        end else if (step_en) begin
            if (fits) begin
                rem <= XLEN'(rem_shift - {1'b0, divisor_mag});
            end else begin
                rem <= rem_shift[XLEN-1:0];
            end
            quo <= {quo[XLEN-2:0], fits};
        end
    end

    assign quo_out = by_zero ? '1 : (quo_neg ? -quo : quo);
    assign rem_out = by_zero ? dividend_raw : (rem_neg ? -rem : rem);

    assign result = want_rem ? rem_out : quo_out;

endmodule

// ==== logic/div_iter_counter.sv ====
`timescale 1ns/1ps

module div_iter_counter #(
    parameter int XLEN = 32
) (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    input  logic step_en,
    output logic last_step
);

    localparam int cnt_w = $clog2(XLEN) + 1;

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
        end else if (step_en) begin
            count <= count + 1'b1;
        end
    end

    assign last_step = step_en && (count == cnt_w'(XLEN - 1));

endmodule

// ==== logic/exe_pkg.sv ====
package exe_pkg;

    localparam int xlen = 32;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_nor,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_div,
        op_divu,
        op_mod,
        op_modu
    } alu_op_e;

    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_e;

    // Decoded instruction handed over from decode
    typedef struct packed {
        alu_op_e           alu_op;
        logic              res_from_mem;
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              gr_we;
        logic              mem_we;
        logic [4:0]        dest;
        logic [xlen-1:0]   imm;
        logic [xlen-1:0]   rj_value;
        logic [xlen-1:0]   rkd_value;
        logic [xlen-1:0]   pc;
    } ds_to_es_t;

    typedef struct packed {
        logic              res_from_mem;
        logic              gr_we;
        logic [4:0]        dest;
        logic [xlen-1:0]   alu_result;
        logic [xlen-1:0]   pc;
    } es_to_ms_t;

    // Forwarding and load-use blocking info back to decode
    typedef struct packed {
        logic              wr_valid;
        logic              load_valid;
        logic [4:0]        dest;
        logic [xlen-1:0]   result;
    } es_fwd_t;

    typedef struct packed {
        logic              en;
        logic [3:0]        wen;
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   wdata;
    } data_sram_req_t;

    typedef struct packed {
        logic [xlen-1:0]   dividend;
        logic [xlen-1:0]   divisor;
        logic              is_signed;
        logic              want_rem;
    } div_req_t;

endpackage

// ==== logic/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ds_to_es_valid,
    input  exe_pkg::ds_to_es_t       ds_to_es,
    output logic                     es_allowin,
    output logic                     es_to_ms_valid,
    output exe_pkg::es_to_ms_t       es_to_ms,
    input  logic                     ms_allowin,
    output exe_pkg::data_sram_req_t  data_sram,
    output exe_pkg::es_fwd_t         es_fwd,
    output logic                     div_start,
    output exe_pkg::div_req_t        div_req,
    output logic                     div_ack,
    input  logic                     div_done,
    input  logic [31:0]              div_result
);

    import exe_pkg::*;

    logic        es_valid;
    logic        es_ready_go;
    ds_to_es_t   ds_r;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [31:0] es_result;
    logic        is_div;
    logic        div_issued;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
        if (ds_to_es_valid && es_allowin) begin
            ds_r <= ds_to_es;
        end
    end

    assign is_div = ds_r.alu_op inside {op_div, op_divu, op_mod, op_modu};

    assign es_ready_go    = !is_div || div_done;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    assign alu_src1 = ds_r.src1_is_pc  ? ds_r.pc  : ds_r.rj_value;
    assign alu_src2 = ds_r.src2_is_imm ? ds_r.imm : ds_r.rkd_value;

    alu u_alu (
        .alu_op (ds_r.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // One start per divide until that divide leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            div_issued <= 1'b0;
        end else if (div_ack) begin
            div_issued <= 1'b0;
        end else if (div_start) begin
            div_issued <= 1'b1;
        end
    end

    assign div_start = es_valid && is_div && !div_issued;
    assign div_ack   = es_to_ms_valid && ms_allowin && is_div;

    assign div_req.dividend  = alu_src1;
    assign div_req.divisor   = alu_src2;
    assign div_req.is_signed = (ds_r.alu_op == op_div) || (ds_r.alu_op == op_mod);
    assign div_req.want_rem  = (ds_r.alu_op == op_mod) || (ds_r.alu_op == op_modu);

    assign es_result = is_div ? div_result : alu_result;

    assign es_to_ms.res_from_mem = ds_r.res_from_mem;
    assign es_to_ms.gr_we        = ds_r.gr_we;
    assign es_to_ms.dest         = ds_r.dest;
    assign es_to_ms.alu_result   = es_result;
    assign es_to_ms.pc           = ds_r.pc;

    // Word access only
    assign data_sram.en    = (ds_r.res_from_mem || ds_r.mem_we) && es_valid;
    assign data_sram.wen   = {4{ds_r.mem_we}};
    assign data_sram.addr  = es_result;
    assign data_sram.wdata = ds_r.rkd_value;

    assign es_fwd.wr_valid   = ds_r.gr_we && es_valid;
    assign es_fwd.load_valid = ds_r.res_from_mem && es_valid;
    assign es_fwd.dest       = ds_r.dest;
    assign es_fwd.result     = es_result;

endmodule

// ==== logic/exe_top.sv ====
`timescale 1ns/1ps

module exe_top #(
    parameter int XLEN = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ds_to_es_valid,
    input  exe_pkg::ds_to_es_t       ds_to_es,
    output logic                     es_allowin,
    output logic                     es_to_ms_valid,
    output exe_pkg::es_to_ms_t       es_to_ms,
    input  logic                     ms_allowin,
    output exe_pkg::data_sram_req_t  data_sram,
    output exe_pkg::es_fwd_t         es_fwd
);

    import exe_pkg::*;

    logic            div_start;
    logic            div_ack;
    logic            div_is_done;
    logic            div_load;
    logic            div_step_en;
    logic            div_last_step;
    div_req_t        div_req;
    div_state_e      div_state;
    logic [XLEN-1:0] div_result;

    assign div_is_done = (div_state == div_done);

    exe_stage u_exe_stage (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_allowin     (es_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms       (es_to_ms),
        .ms_allowin     (ms_allowin),
        .data_sram      (data_sram),
        .es_fwd         (es_fwd),
        .div_start      (div_start),
        .div_req        (div_req),
        .div_ack        (div_ack),
        .div_done       (div_is_done),
        .div_result     (div_result)
    );

    div_ctrl #(
        .XLEN (XLEN)
    ) u_div_ctrl (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .last_step (div_last_step),
        .ack       (div_ack),
        .state     (div_state),
        .step_en   (div_step_en),
        .load      (div_load)
    );

    div_iter_counter #(
        .XLEN (XLEN)
    ) u_div_iter_counter (
        .clk       (clk),
        .reset     (reset),
        .clear     (div_load),
        .step_en   (div_step_en),
        .last_step (div_last_step)
    );

    div_datapath #(
        .XLEN (XLEN)
    ) u_div_datapath (
        .clk     (clk),
        .load    (div_load),
        .step_en (div_step_en),
        .req     (div_req),
        .result  (div_result)
    );

endmodule

// ==== verilog.f ====
logic/exe_pkg.sv
logic/alu.sv
logic/div_ctrl.sv
logic/div_iter_counter.sv
logic/div_datapath.sv
logic/exe_stage.sv
logic/exe_top.sv
bench/exe_tb.sv
